/* common/periph_bus_pkg.sv */
package periph_bus_pkg;

   ////////////////////////////////////////
   // Core bus widths
   ////////////////////////////////////////

   localparam int DATA_W = 32;
   localparam int ADDR_W = 32;
   localparam int BE_W   = 4;

   ////////////////////////////////////////
   // Address map
   ////////////////////////////////////////

   // Block field, bits 11:8
   localparam int BLK_LSB  = 8;
   localparam int BLK_W    = 4;
   // Instance field, bits 7:5
   localparam int INST_LSB = 5;
   localparam int INST_W   = 3;
   // Word index inside an instance, bits 4:2
   localparam int REG_LSB  = 2;
   localparam int REG_W    = 3;

   // Upper address bits 31:12 of the unit
   localparam logic [ADDR_W-BLK_LSB-BLK_W-1:0] PERIPH_BASE = 20'h10000;

   localparam logic [BLK_W-1:0] BLK_TIMER = 4'd0;
   localparam logic [BLK_W-1:0] BLK_PWM   = 4'd1;

   // Timer registers
   localparam logic [REG_W-1:0] TIM_CTRL     = 3'd0;
   localparam logic [REG_W-1:0] TIM_THRESH_L = 3'd1;
   localparam logic [REG_W-1:0] TIM_THRESH_H = 3'd2;
   localparam logic [REG_W-1:0] TIM_OUT_L    = 3'd3;
   localparam logic [REG_W-1:0] TIM_OUT_H    = 3'd4;

   // PWM registers
   localparam logic [REG_W-1:0] PWM_EN         = 3'd0;
   localparam logic [REG_W-1:0] PWM_PERIOD_DIV = 3'd1;
   localparam logic [REG_W-1:0] PWM_SETPOINT   = 3'd2;

endpackage

/* common/periph_cfg_pkg.sv */
package periph_cfg_pkg;

   ////////////////////////////////////////
   // Instance counts
   ////////////////////////////////////////

   // Timer 0 drives the core timer interrupt
   localparam int TIM_INST_NUM = 2;

   // One output pin per channel
   localparam int PWM_INST_NUM = 2;

   ////////////////////////////////////////
   // Timer fields
   ////////////////////////////////////////

   // mtime and threshold, read as two words
   localparam int TIM_CNT_W = 64;

   ////////////////////////////////////////
   // PWM fields
   ////////////////////////////////////////

   // Setpoint and modulation counter, 0 to 255
   localparam int MOD_WIDTH = 8;

   // Prescaler limit
   localparam int PWM_DIV_W = 8;

endpackage

/* filelist.f */
common/periph_bus_pkg.sv
common/periph_cfg_pkg.sv
hw/periph_addr_decode.sv
timer/timer_block.sv
pwm/pwm_block.sv
hw/periph_read_mux.sv
hw/peripheral_unit.sv
tests/periph_checker.sv
tests/tb_peripheral_unit.sv

/* hw/periph_addr_decode.sv */
module periph_addr_decode (
   input  logic                                  clk,
   input  logic                                  i_arst_n,
   input  logic                                  i_req,
   input  logic                                  i_we,
   input  logic [periph_bus_pkg::ADDR_W-1:0]     i_addr,
   output logic                                  o_gnt,
   output logic [periph_cfg_pkg::TIM_INST_NUM-1:0] o_tim_wr,
   output logic [periph_cfg_pkg::PWM_INST_NUM-1:0] o_pwm_wr,
   output logic [periph_bus_pkg::REG_W-1:0]      o_reg_sel,
   output logic                                  o_acc_q,
   output logic                                  o_rd_hit_q,
   output logic [periph_bus_pkg::BLK_W-1:0]      o_rd_blk_q,
   output logic [periph_bus_pkg::INST_W-1:0]     o_rd_inst_q,
   output logic [periph_bus_pkg::REG_W-1:0]      o_rd_reg_q
);
   import periph_bus_pkg::*;
   import periph_cfg_pkg::*;

   logic [BLK_W-1:0]  blk;
   logic [INST_W-1:0] inst;
   logic              base_ok;
   logic              hit;

   // Never busy
   assign o_gnt = i_req;

   assign blk       = i_addr[BLK_LSB +: BLK_W];
   assign inst      = i_addr[INST_LSB +: INST_W];
   assign o_reg_sel = i_addr[REG_LSB +: REG_W];
   assign base_ok   = i_addr[ADDR_W-1:BLK_LSB+BLK_W] == PERIPH_BASE;

   assign hit = base_ok &&
                ((blk == BLK_TIMER && inst < INST_W'(TIM_INST_NUM)) ||
                 (blk == BLK_PWM && inst < INST_W'(PWM_INST_NUM)));

   always_comb begin
      for (int k = 0; k < TIM_INST_NUM; k++) begin
         o_tim_wr[k] = i_req && i_we && hit && blk == BLK_TIMER && inst == INST_W'(k);
      end
      for (int k = 0; k < PWM_INST_NUM; k++) begin
         o_pwm_wr[k] = i_req && i_we && hit && blk == BLK_PWM && inst == INST_W'(k);
      end
   end

   ////////////////////////////////////////
   // Selection for the result stage
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_acc_q    <= 1'b0;
         o_rd_hit_q <= 1'b0;
      end else begin
         o_acc_q    <= i_req;
         o_rd_hit_q <= i_req && !i_we && hit;
      end
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_rd_blk_q  <= '0;
         o_rd_inst_q <= '0;
         o_rd_reg_q  <= '0;
      end else if (i_req) begin
         o_rd_blk_q  <= blk;
         o_rd_inst_q <= inst;
         o_rd_reg_q  <= o_reg_sel;
      end
   end

   a_one_strobe : assert property (@(posedge clk) disable iff (!i_arst_n)
      $onehot0({o_tim_wr, o_pwm_wr}));

endmodule

/* hw/periph_read_mux.sv */
module periph_read_mux (
   input  logic                                 clk,
   input  logic                                 i_arst_n,
   input  logic                                 i_acc_q,
   input  logic                                 i_rd_hit_q,
   input  logic [periph_bus_pkg::BLK_W-1:0]     i_rd_blk_q,
   input  logic [periph_bus_pkg::INST_W-1:0]    i_rd_inst_q,
   input  logic [periph_bus_pkg::REG_W-1:0]     i_rd_reg_q,
   input  logic [periph_cfg_pkg::TIM_INST_NUM-1:0] i_tim_en,
   input  logic [periph_cfg_pkg::TIM_CNT_W-1:0] i_tim_thresh [periph_cfg_pkg::TIM_INST_NUM],
   input  logic [periph_cfg_pkg::TIM_CNT_W-1:0] i_tim_mtime [periph_cfg_pkg::TIM_INST_NUM],
   input  logic [periph_cfg_pkg::PWM_INST_NUM-1:0] i_pwm_en,
   input  logic [periph_cfg_pkg::PWM_DIV_W-1:0] i_pwm_div [periph_cfg_pkg::PWM_INST_NUM],
   input  logic [periph_cfg_pkg::MOD_WIDTH-1:0] i_pwm_setpoint [periph_cfg_pkg::PWM_INST_NUM],
   output logic                                 o_rvalid,
   output logic [periph_bus_pkg::DATA_W-1:0]    o_rdata
);
   import periph_bus_pkg::*;

   always_comb begin
      o_rdata = '0;
      if (i_rd_hit_q && i_rd_blk_q == BLK_TIMER) begin
         for (int k = 0; k < $size(i_tim_thresh); k++) begin
            if (i_rd_inst_q == INST_W'(k)) begin
               case (i_rd_reg_q)
                  TIM_CTRL:     o_rdata = DATA_W'(i_tim_en[k]);
                  TIM_THRESH_L: o_rdata = i_tim_thresh[k][DATA_W-1:0];
                  TIM_THRESH_H: o_rdata = i_tim_thresh[k][2*DATA_W-1:DATA_W];
                  TIM_OUT_L:    o_rdata = i_tim_mtime[k][DATA_W-1:0];
                  TIM_OUT_H:    o_rdata = i_tim_mtime[k][2*DATA_W-1:DATA_W];
                  default:      o_rdata = '0;
               endcase
            end
         end
      end else if (i_rd_hit_q && i_rd_blk_q == BLK_PWM) begin
         for (int k = 0; k < $size(i_pwm_div); k++) begin
            if (i_rd_inst_q == INST_W'(k)) begin
               case (i_rd_reg_q)
                  PWM_EN:         o_rdata = DATA_W'(i_pwm_en[k]);
                  PWM_PERIOD_DIV: o_rdata = DATA_W'(i_pwm_div[k]);
                  PWM_SETPOINT:   o_rdata = DATA_W'(i_pwm_setpoint[k]);
                  default:        o_rdata = '0;
               endcase
            end
         end
      end
   end

   // Response one cycle after every accepted request
   assign o_rvalid = i_acc_q;

   a_quiet_bus : assert property (@(posedge clk) disable iff (!i_arst_n)
      !o_rvalid |-> (!i_rd_hit_q && o_rdata == '0));

endmodule

/* hw/peripheral_unit.sv */
module peripheral_unit (
   input  logic                                    clk,
   input  logic                                    i_arst_n,
   input  logic                                    i_req,
   input  logic                                    i_we,
   input  logic [periph_bus_pkg::ADDR_W-1:0]       i_addr,
   input  logic [periph_bus_pkg::DATA_W-1:0]       i_wdata,
   input  logic [periph_bus_pkg::BE_W-1:0]         i_be,
   output logic                                    o_gnt,
   output logic                                    o_rvalid,
   output logic [periph_bus_pkg::DATA_W-1:0]       o_rdata,
   output logic                                    o_timer_intr,
   output logic [periph_cfg_pkg::PWM_INST_NUM-1:0] o_pwm_out
);
   import periph_bus_pkg::*;
   import periph_cfg_pkg::*;

   logic [TIM_INST_NUM-1:0] tim_wr;
   logic [PWM_INST_NUM-1:0] pwm_wr;
   logic [REG_W-1:0]        reg_sel;
   logic                    acc_q;
   logic                    rd_hit_q;
   logic [BLK_W-1:0]        rd_blk_q;
   logic [INST_W-1:0]       rd_inst_q;
   logic [REG_W-1:0]        rd_reg_q;

   logic [TIM_INST_NUM-1:0] tim_en;
   logic [TIM_INST_NUM-1:0] tim_int;
   logic [TIM_CNT_W-1:0]    tim_thresh [TIM_INST_NUM];
   logic [TIM_CNT_W-1:0]    tim_mtime [TIM_INST_NUM];

   logic [PWM_INST_NUM-1:0] pwm_en;
   logic [PWM_DIV_W-1:0]    pwm_div [PWM_INST_NUM];
   logic [MOD_WIDTH-1:0]    pwm_setpoint [PWM_INST_NUM];

   ////////////////////////////////////////
   // Decode
   ////////////////////////////////////////

   periph_addr_decode u_decode (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .i_req       (i_req),
      .i_we        (i_we),
      .i_addr      (i_addr),
      .o_gnt       (o_gnt),
      .o_tim_wr    (tim_wr),
      .o_pwm_wr    (pwm_wr),
      .o_reg_sel   (reg_sel),
      .o_acc_q     (acc_q),
      .o_rd_hit_q  (rd_hit_q),
      .o_rd_blk_q  (rd_blk_q),
      .o_rd_inst_q (rd_inst_q),
      .o_rd_reg_q  (rd_reg_q)
   );

   ////////////////////////////////////////
   // Execute
   ////////////////////////////////////////

   genvar gt;
   generate
      for (gt = 0; gt < TIM_INST_NUM; gt++) begin : g_timer
         timer_block u_timer (
            .clk       (clk),
            .i_arst_n  (i_arst_n),
            .i_wr      (tim_wr[gt]),
            .i_reg_sel (reg_sel),
            .i_wdata   (i_wdata),
            .i_be      (i_be),
            .o_en      (tim_en[gt]),
            .o_thresh  (tim_thresh[gt]),
            .o_mtime   (tim_mtime[gt]),
            .o_int     (tim_int[gt])
         );
      end
   endgenerate

   genvar gp;
   generate
      for (gp = 0; gp < PWM_INST_NUM; gp++) begin : g_pwm
         pwm_block u_pwm (
            .clk          (clk),
            .i_arst_n     (i_arst_n),
            .i_wr         (pwm_wr[gp]),
            .i_reg_sel    (reg_sel),
            .i_wdata      (i_wdata),
            .i_be         (i_be),
            .o_en         (pwm_en[gp]),
            .o_period_div (pwm_div[gp]),
            .o_setpoint   (pwm_setpoint[gp]),
            .o_pwm        (o_pwm_out[gp])
         );
      end
   endgenerate

   // Only timer 0 reaches the core
   assign o_timer_intr = tim_int[0];

   ////////////////////////////////////////
   // Result
   ////////////////////////////////////////

   periph_read_mux u_read_mux (
      .clk            (clk),
      .i_arst_n       (i_arst_n),
      .i_acc_q        (acc_q),
      .i_rd_hit_q     (rd_hit_q),
      .i_rd_blk_q     (rd_blk_q),
      .i_rd_inst_q    (rd_inst_q),
      .i_rd_reg_q     (rd_reg_q),
      .i_tim_en       (tim_en),
      .i_tim_thresh   (tim_thresh),
      .i_tim_mtime    (tim_mtime),
      .i_pwm_en       (pwm_en),
      .i_pwm_div      (pwm_div),
      .i_pwm_setpoint (pwm_setpoint),
      .o_rvalid       (o_rvalid),
      .o_rdata        (o_rdata)
   );

endmodule

/* pwm/pwm_block.sv */
module pwm_block (
   input  logic                                 clk,
   input  logic                                 i_arst_n,
   input  logic                                 i_wr,
   input  logic [periph_bus_pkg::REG_W-1:0]     i_reg_sel,
   input  logic [periph_bus_pkg::DATA_W-1:0]    i_wdata,
   input  logic [periph_bus_pkg::BE_W-1:0]      i_be,
   output logic                                 o_en,
   output logic [periph_cfg_pkg::PWM_DIV_W-1:0] o_period_div,
   output logic [periph_cfg_pkg::MOD_WIDTH-1:0] o_setpoint,
   output logic                                 o_pwm
);
   import periph_bus_pkg::*;
   import periph_cfg_pkg::*;

   logic [PWM_DIV_W-1:0] presc;
   logic [MOD_WIDTH-1:0] mod_cnt;
   logic                 div_wr;

   // All fields sit in byte lane 0
   assign div_wr = i_wr && i_be[0] && i_reg_sel == PWM_PERIOD_DIV;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_en         <= 1'b0;
         o_period_div <= '0;
         o_setpoint   <= '0;
      end else if (i_wr && i_be[0]) begin
         case (i_reg_sel)
            PWM_EN:         o_en         <= i_wdata[0];
            PWM_PERIOD_DIV: o_period_div <= i_wdata[PWM_DIV_W-1:0];
            PWM_SETPOINT:   o_setpoint   <= i_wdata[MOD_WIDTH-1:0];
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////
   // Prescaler and modulation counter
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         presc   <= '0;
         mod_cnt <= '0;
      end else if (!o_en) begin
         presc   <= '0;
         mod_cnt <= '0;
      end else if (div_wr) begin
         // Restart the period so the prescaler never runs past a smaller divider
         presc <= '0;
      end else if (presc == o_period_div) begin
         presc   <= '0;
         mod_cnt <= mod_cnt + MOD_WIDTH'(1);
      end else begin
         presc <= presc + PWM_DIV_W'(1);
      end
   end

   assign o_pwm = o_en && (mod_cnt < o_setpoint);

   a_presc_range : assert property (@(posedge clk) disable iff (!i_arst_n)
      presc <= o_period_div);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_peripheral_unit -f filelist.f -Mdir obj_dir &&
./obj_dir/Vtb_peripheral_unit | tee /dev/stderr | grep -qx "test passed" &&
echo "Simulation result: PASS" ||
{ echo "Simulation result: FAIL"; exit 1; }

/* tests/periph_checker.sv */
module periph_checker (
   input  logic                                    clk,
   input  logic                                    i_arst_n,
   input  logic                                    i_req,
   input  logic                                    i_we,
   input  logic [periph_bus_pkg::ADDR_W-1:0]       i_addr,
   input  logic [periph_bus_pkg::DATA_W-1:0]       i_wdata,
   input  logic [periph_bus_pkg::BE_W-1:0]         i_be,
   input  logic                                    i_gnt,
   input  logic                                    i_rvalid,
   input  logic [periph_bus_pkg::DATA_W-1:0]       i_rdata,
   input  logic                                    i_timer_intr,
   input  logic [periph_cfg_pkg::PWM_INST_NUM-1:0] i_pwm_out,
   output int                                      o_err_rd,
   output int                                      o_err_bus,
   output int                                      o_err_tim,
   output int                                      o_err_pwm
);
   import periph_bus_pkg::*;
   import periph_cfg_pkg::*;

   logic                 tim_en_m [TIM_INST_NUM];
   logic [TIM_CNT_W-1:0] thresh_m [TIM_INST_NUM];
   logic [TIM_CNT_W-1:0] mtime_m [TIM_INST_NUM];
   logic                 pwm_en_m [PWM_INST_NUM];
   logic [PWM_DIV_W-1:0] div_m [PWM_INST_NUM];
   logic [MOD_WIDTH-1:0] sp_m [PWM_INST_NUM];
   logic                 win_act [PWM_INST_NUM];
   int                   win_left [PWM_INST_NUM];
   int                   win_high [PWM_INST_NUM];
   logic                 pend_v;
   logic [ADDR_W-1:0]    pend_a;
   logic [DATA_W-1:0]    pend_d;
   logic                 exp_int;
   int                   err_rd = 0;
   int                   err_bus = 0;
   int                   err_tim = 0;
   int                   err_pwm = 0;

   assign o_err_rd  = err_rd;
   assign o_err_bus = err_bus;
   assign o_err_tim = err_tim;
   assign o_err_pwm = err_pwm;

   ////////////////////////////////////////
   // Reference functions
   ////////////////////////////////////////

   function automatic logic [DATA_W-1:0] merge_be(input logic [DATA_W-1:0] old_w,
         input logic [DATA_W-1:0] new_w, input logic [BE_W-1:0] be);
      logic [DATA_W-1:0] res;
      res = old_w;
      for (int b = 0; b < BE_W; b++) begin
         if (be[b]) begin
            res[b*8 +: 8] = new_w[b*8 +: 8];
         end
      end
      return res;
   endfunction

   // High cycles in one full modulation period
   function automatic int pwm_high_ref(input logic [MOD_WIDTH-1:0] sp,
         input logic [PWM_DIV_W-1:0] div);
      return int'(sp) * (int'(div) + 1);
   endfunction

   function automatic logic [DATA_W-1:0] read_ref(input logic [ADDR_W-1:0] addr);
      logic [BLK_W-1:0]  blk;
      logic [INST_W-1:0] inst;
      logic [REG_W-1:0]  rsel;
      logic [DATA_W-1:0] res;
      blk  = addr[BLK_LSB +: BLK_W];
      inst = addr[INST_LSB +: INST_W];
      rsel = addr[REG_LSB +: REG_W];
      res  = '0;
      if (addr[ADDR_W-1:BLK_LSB+BLK_W] == PERIPH_BASE) begin
         for (int k = 0; k < TIM_INST_NUM; k++) begin
            if (blk == BLK_TIMER && inst == INST_W'(k)) begin
               case (rsel)
                  TIM_CTRL:     res = DATA_W'(tim_en_m[k]);
                  TIM_THRESH_L: res = thresh_m[k][DATA_W-1:0];
                  TIM_THRESH_H: res = thresh_m[k][2*DATA_W-1:DATA_W];
                  TIM_OUT_L:    res = mtime_m[k][DATA_W-1:0];
                  TIM_OUT_H:    res = mtime_m[k][2*DATA_W-1:DATA_W];
                  default:      res = '0;
               endcase
            end
         end
         for (int k = 0; k < PWM_INST_NUM; k++) begin
            if (blk == BLK_PWM && inst == INST_W'(k)) begin
               case (rsel)
                  PWM_EN:         res = DATA_W'(pwm_en_m[k]);
                  PWM_PERIOD_DIV: res = DATA_W'(div_m[k]);
                  PWM_SETPOINT:   res = DATA_W'(sp_m[k]);
                  default:        res = '0;
               endcase
            end
         end
      end
      return res;
   endfunction

   ////////////////////////////////////////
   // Register model
   ////////////////////////////////////////

   task automatic model_reset();
      for (int k = 0; k < TIM_INST_NUM; k++) begin
         tim_en_m[k] = 1'b0;
         thresh_m[k] = '0;
         mtime_m[k]  = '0;
      end
      for (int k = 0; k < PWM_INST_NUM; k++) begin
         pwm_en_m[k] = 1'b0;
         div_m[k]    = '0;
         sp_m[k]     = '0;
         win_act[k]  = 1'b0;
      end
      pend_v = 1'b0;
   endtask

   task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wd,
         input logic [BE_W-1:0] be);
      logic [BLK_W-1:0]  blk;
      logic [INST_W-1:0] inst;
      logic [REG_W-1:0]  rsel;
      logic [DATA_W-1:0] m;
      blk  = addr[BLK_LSB +: BLK_W];
      inst = addr[INST_LSB +: INST_W];
      rsel = addr[REG_LSB +: REG_W];
      if (addr[ADDR_W-1:BLK_LSB+BLK_W] != PERIPH_BASE) begin
         return;
      end
      for (int k = 0; k < TIM_INST_NUM; k++) begin
         if (blk == BLK_TIMER && inst == INST_W'(k)) begin
            case (rsel)
               TIM_CTRL: begin
                  m = merge_be(DATA_W'(tim_en_m[k]), wd, be);
                  tim_en_m[k] = m[0];
               end
               TIM_THRESH_L:
                  thresh_m[k][DATA_W-1:0] = merge_be(thresh_m[k][DATA_W-1:0], wd, be);
               TIM_THRESH_H:
                  thresh_m[k][2*DATA_W-1:DATA_W] =
                     merge_be(thresh_m[k][2*DATA_W-1:DATA_W], wd, be);
               default: ;
            endcase
         end
      end
      for (int k = 0; k < PWM_INST_NUM; k++) begin
         if (blk == BLK_PWM && inst == INST_W'(k)) begin
            // Any write may shift the phase, so the running window is dropped
            win_act[k] = 1'b0;
            case (rsel)
               PWM_EN: begin
                  m = merge_be(DATA_W'(pwm_en_m[k]), wd, be);
                  if (!pwm_en_m[k] && m[0]) begin
                     win_act[k]  = 1'b1;
                     win_left[k] = 256 * (int'(div_m[k]) + 1);
                     win_high[k] = 0;
                  end
                  pwm_en_m[k] = m[0];
               end
               PWM_PERIOD_DIV: begin
                  m = merge_be(DATA_W'(div_m[k]), wd, be);
                  div_m[k] = m[PWM_DIV_W-1:0];
               end
               PWM_SETPOINT: begin
                  m = merge_be(DATA_W'(sp_m[k]), wd, be);
                  sp_m[k] = m[MOD_WIDTH-1:0];
               end
               default: ;
            endcase
         end
      end
   endtask

   ////////////////////////////////////////
   // Compare at every rising edge
   ////////////////////////////////////////

   always @(posedge clk) begin
      if (!i_arst_n) begin
         model_reset();
      end else begin
         if (i_gnt !== i_req) begin
            err_bus++;
            $display("FAILED bus_strobe gnt: expected %b, actual %b", i_req, i_gnt);
         end
         if (i_rvalid !== pend_v) begin
            err_bus++;
            $display("FAILED bus_strobe rvalid: expected %b, actual %b", pend_v, i_rvalid);
         end
         if (pend_v && i_rdata !== pend_d) begin
            err_rd++;
            $display("FAILED bus_read @%h: expected %h, actual %h", pend_a, pend_d, i_rdata);
         end

         exp_int = tim_en_m[0] && (mtime_m[0] >= thresh_m[0]);
         if (i_timer_intr !== exp_int) begin
            err_tim++;
            $display("FAILED timer_intr: expected %b, actual %b", exp_int, i_timer_intr);
         end

         for (int k = 0; k < PWM_INST_NUM; k++) begin
            if (!pwm_en_m[k] && i_pwm_out[k] !== 1'b0) begin
               err_pwm++;
               $display("FAILED pwm_idle ch%0d: expected 0, actual %b", k, i_pwm_out[k]);
            end
            if (win_act[k]) begin
               win_high[k] += (i_pwm_out[k] === 1'b1) ? 1 : 0;
               win_left[k]--;
               if (win_left[k] == 0) begin
                  win_act[k] = 1'b0;
                  if (win_high[k] != pwm_high_ref(sp_m[k], div_m[k])) begin
                     err_pwm++;
                     $display("FAILED pwm_duty ch%0d: expected %0d, actual %0d", k,
                              pwm_high_ref(sp_m[k], div_m[k]), win_high[k]);
                  end
               end
            end
         end

         for (int k = 0; k < TIM_INST_NUM; k++) begin
            if (tim_en_m[k]) begin
               mtime_m[k] = mtime_m[k] + TIM_CNT_W'(1);
            end
         end
         if (i_req && i_we) begin
            model_write(i_addr, i_wdata, i_be);
         end

         // Read word as it stands after this edge
         pend_v = i_req;
         pend_a = i_addr;
         pend_d = (i_req && !i_we) ? read_ref(i_addr) : '0;
      end
   end

endmodule

/* tests/tb_peripheral_unit.sv */
module tb_peripheral_unit;
   import periph_bus_pkg::*;
   import periph_cfg_pkg::*;

   // Longest PWM window uses a divider of 15
   localparam int PWM_WIN_MAX = 256 * 16;
   // Reset, reset reads, strobes, timer, six PWM windows, random phase, margin
   localparam int CYCLE_LIMIT = 10 + 40 + 20 + 150 + 6 * (PWM_WIN_MAX + 12)
                                + 48 * 4 + 12 * 4 + 2000;

   logic                    clk;
   logic                    arst_n;
   logic                    req;
   logic                    we;
   logic [ADDR_W-1:0]       addr;
   logic [DATA_W-1:0]       wdata;
   logic [BE_W-1:0]         be;
   logic                    gnt;
   logic                    rvalid;
   logic [DATA_W-1:0]       rdata;
   logic                    timer_intr;
   logic [PWM_INST_NUM-1:0] pwm_out;
   int                      err_rd;
   int                      err_bus;
   int                      err_tim;
   int                      err_pwm;
   int                      total;
   int                      cycles = 0;
   logic [31:0]             seed;
   logic [PWM_DIV_W-1:0]    div_v;
   logic [MOD_WIDTH-1:0]    sp_v;

   peripheral_unit UUT (
      .clk          (clk),
      .i_arst_n     (arst_n),
      .i_req        (req),
      .i_we         (we),
      .i_addr       (addr),
      .i_wdata      (wdata),
      .i_be         (be),
      .o_gnt        (gnt),
      .o_rvalid     (rvalid),
      .o_rdata      (rdata),
      .o_timer_intr (timer_intr),
      .o_pwm_out    (pwm_out)
   );

   periph_checker u_checker (
      .clk          (clk),
      .i_arst_n     (arst_n),
      .i_req        (req),
      .i_we         (we),
      .i_addr       (addr),
      .i_wdata      (wdata),
      .i_be         (be),
      .i_gnt        (gnt),
      .i_rvalid     (rvalid),
      .i_rdata      (rdata),
      .i_timer_intr (timer_intr),
      .i_pwm_out    (pwm_out),
      .o_err_rd     (err_rd),
      .o_err_bus    (err_bus),
      .o_err_tim    (err_tim),
      .o_err_pwm    (err_pwm)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
         $display("test failed");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Helpers and bus tasks
   ////////////////////////////////////////

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [ADDR_W-1:0] reg_addr(input logic [BLK_W-1:0] blk,
         input logic [INST_W-1:0] inst, input logic [REG_W-1:0] rsel);
      return {PERIPH_BASE, blk, inst, rsel, 2'b00};
   endfunction

   // Leaves the request up so the next call runs back to back
   task automatic bus_issue(input logic wr, input logic [ADDR_W-1:0] a,
         input logic [DATA_W-1:0] d, input logic [BE_W-1:0] b);
      @(posedge clk);
      req   <= 1'b1;
      we    <= wr;
      addr  <= a;
      wdata <= d;
      be    <= b;
   endtask

   task automatic bus_idle(input int n);
      repeat (n) begin
         @(posedge clk);
         req <= 1'b0;
         we  <= 1'b0;
      end
   endtask

   task automatic write_reg(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
         input logic [BE_W-1:0] b);
      bus_issue(1'b1, a, d, b);
      bus_idle(1);
   endtask

   task automatic read_reg(input logic [ADDR_W-1:0] a);
      bus_issue(1'b0, a, '0, '0);
      bus_idle(1);
   endtask

   task automatic random_write_read();
      logic [31:0]       r;
      logic [BLK_W-1:0]  blk;
      logic [ADDR_W-1:0] a;
      seed = lcg_step(seed);
      r    = seed;
      blk  = r[0] ? BLK_PWM : BLK_TIMER;
      // Writable words are 0 to 2 in both blocks
      a    = reg_addr(blk, INST_W'(r[1]), REG_W'(r[9:8] % 2'd3));
      seed = lcg_step(seed);
      write_reg(a, seed, r[7:4]);
      read_reg(a);
   endtask

   task automatic unmapped_access();
      logic [ADDR_W-1:0] a;
      seed = lcg_step(seed);
      case (seed[1:0])
         2'd0:    a = {PERIPH_BASE ^ {seed[31:13], 1'b1}, seed[11:0]};
         2'd1:    a = reg_addr(BLK_TIMER, seed[14:12] | 3'b010, seed[4:2]);
         2'd2:    a = reg_addr(seed[19:16] | 4'h2, seed[7:5], seed[4:2]);
         default: a = reg_addr(BLK_PWM, INST_W'(seed[5]), {seed[9], 2'b11});
      endcase
      write_reg(a, lcg_step(seed), 4'hf);
      read_reg(a);
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin
      arst_n = 1'b0;
      req    = 1'b0;
      we     = 1'b0;
      addr   = '0;
      wdata  = '0;
      be     = '0;
      seed   = 32'h0d1a_47d9;
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;

      // Reset state of every mapped word
      for (int k = 0; k < TIM_INST_NUM; k++) begin
         for (int r = 0; r < 5; r++) begin
            read_reg(reg_addr(BLK_TIMER, INST_W'(k), REG_W'(r)));
         end
      end
      for (int k = 0; k < PWM_INST_NUM; k++) begin
         for (int r = 0; r < 3; r++) begin
            read_reg(reg_addr(BLK_PWM, INST_W'(k), REG_W'(r)));
         end
      end

      // Single and back-to-back requests
      read_reg(reg_addr(BLK_TIMER, 3'd0, TIM_CTRL));
      bus_idle(2);
      bus_issue(1'b1, reg_addr(BLK_PWM, 3'd0, PWM_SETPOINT), 32'h5a, 4'h1);
      bus_issue(1'b0, reg_addr(BLK_PWM, 3'd0, PWM_SETPOINT), '0, '0);
      bus_issue(1'b0, reg_addr(BLK_TIMER, 3'd1, TIM_THRESH_L), '0, '0);
      bus_issue(1'b1, reg_addr(BLK_TIMER, 3'd1, TIM_THRESH_L), 32'hdead_beef, 4'b0101);
      bus_issue(1'b0, reg_addr(BLK_TIMER, 3'd1, TIM_THRESH_L), '0, '0);
      bus_idle(3);

      // Timer 1 alone must not reach the core interrupt
      write_reg(reg_addr(BLK_TIMER, 3'd0, TIM_THRESH_L), 32'd24, 4'hf);
      write_reg(reg_addr(BLK_TIMER, 3'd0, TIM_THRESH_H), 32'd0, 4'hf);
      write_reg(reg_addr(BLK_TIMER, 3'd1, TIM_CTRL), 32'd1, 4'h1);
      bus_idle(40);
      write_reg(reg_addr(BLK_TIMER, 3'd1, TIM_CTRL), 32'd0, 4'h1);
      write_reg(reg_addr(BLK_TIMER, 3'd0, TIM_CTRL), 32'd1, 4'h1);
      read_reg(reg_addr(BLK_TIMER, 3'd0, TIM_OUT_L));
      read_reg(reg_addr(BLK_TIMER, 3'd0, TIM_OUT_L));
      while (!timer_intr) begin
         @(posedge clk);
      end
      read_reg(reg_addr(BLK_TIMER, 3'd0, TIM_OUT_L));
      read_reg(reg_addr(BLK_TIMER, 3'd0, TIM_OUT_H));
      write_reg(reg_addr(BLK_TIMER, 3'd0, TIM_CTRL), 32'd0, 4'h1);

      // One full modulation period per trial
      for (int ch = 0; ch < PWM_INST_NUM; ch++) begin
         for (int t = 0; t < 3; t++) begin
            seed  = lcg_step(seed);
            div_v = {4'd0, seed[3:0]};
            sp_v  = (t == 0) ? 8'd0 : ((t == 1) ? seed[15:8] : 8'hff);
            write_reg(reg_addr(BLK_PWM, INST_W'(ch), PWM_PERIOD_DIV), DATA_W'(div_v), 4'h1);
            write_reg(reg_addr(BLK_PWM, INST_W'(ch), PWM_SETPOINT), DATA_W'(sp_v), 4'h1);
            write_reg(reg_addr(BLK_PWM, INST_W'(ch), PWM_EN), 32'd1, 4'h1);
            bus_idle(256 * (int'(div_v) + 1) + 4);
            write_reg(reg_addr(BLK_PWM, INST_W'(ch), PWM_EN), 32'd0, 4'h1);
         end
      end

      repeat (48) random_write_read();
      repeat (12) unmapped_access();
      bus_idle(4);

      total = err_rd + err_bus + err_tim + err_pwm;
      $display("Errors: read %0d, bus %0d, timer %0d, pwm %0d, total %0d",
               err_rd, err_bus, err_tim, err_pwm, total);
      if (total == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

/* timer/timer_block.sv */
module timer_block (
   input  logic                                 clk,
   input  logic                                 i_arst_n,
   input  logic                                 i_wr,
   input  logic [periph_bus_pkg::REG_W-1:0]     i_reg_sel,
   input  logic [periph_bus_pkg::DATA_W-1:0]    i_wdata,
   input  logic [periph_bus_pkg::BE_W-1:0]      i_be,
   output logic                                 o_en,
   output logic [periph_cfg_pkg::TIM_CNT_W-1:0] o_thresh,
   output logic [periph_cfg_pkg::TIM_CNT_W-1:0] o_mtime,
   output logic                                 o_int
);
   import periph_bus_pkg::*;
   import periph_cfg_pkg::*;

   ////////////////////////////////////////
   // Register writes
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_en     <= 1'b0;
         o_thresh <= '0;
      end else if (i_wr) begin
         case (i_reg_sel)
            TIM_CTRL: begin
               if (i_be[0]) begin
                  o_en <= i_wdata[0];
               end
            end
            TIM_THRESH_L: begin
               for (int b = 0; b < BE_W; b++) begin
                  if (i_be[b]) begin
                     o_thresh[b*8 +: 8] <= i_wdata[b*8 +: 8];
                  end
               end
            end
            TIM_THRESH_H: begin
               for (int b = 0; b < BE_W; b++) begin
                  if (i_be[b]) begin
                     o_thresh[DATA_W + b*8 +: 8] <= i_wdata[b*8 +: 8];
                  end
               end
            end
            // OUT words are read-only
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////
   // Counter and compare
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_mtime <= '0;
      end else if (o_en) begin
         o_mtime <= o_mtime + TIM_CNT_W'(1);
      end
   end

   // Level interrupt, stays up until the threshold moves or the timer stops
   assign o_int = o_en && (o_mtime >= o_thresh);

   a_int_holds : assert property (@(posedge clk) disable iff (!i_arst_n)
      o_int && !i_wr |=> o_int);

endmodule
